/* filelist.f */
+incdir+include
verilog/cn_neuron_pkg.sv
verilog/cn_host_pkg.sv
verilog/host_param_bank.sv
verilog/wave_sample_buffer.sv
verilog/if_neuron.sv
verilog/cn_drive_core.sv
verilog/cn_node_top.sv
tests/tb_cn_node.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cortical node testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_cn_node -Mdir obj_dir -o tb_cn_node
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_cn_node > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "Test failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished clean"
exit 0

/* tests/tb_cn_node.sv */
`timescale 1ns/10ps

`include "cn_params.svh"

module tb_cn_node;

    localparam int CLK_HALF      = 10;  // 20 ns tick
    localparam int RESET_CYCLES  = 10;
    localparam int IDLE_CYCLES   = 40;
    localparam int EXTRA_CYCLES  = 100; // constant drive on extra neuron 1
    localparam int SETTLE_CYCLES = 2;   // last extra1 spike still in flight
    localparam int STOP_CYCLES   = 60;
    localparam int RAND_CYCLES   = 200; // per gain setting
    localparam int PLAY_CYCLES   = 30;
    localparam int CONST_CYCLES  = 20;
    localparam int HOLD_CYCLES   = 5;   // sim_reset pulse length
    localparam int LOAD_CYCLES   = 16;  // host writes and pipe words
    localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + EXTRA_CYCLES + SETTLE_CYCLES
        + STOP_CYCLES + 3 * RAND_CYCLES + PLAY_CYCLES + CONST_CYCLES + HOLD_CYCLES
        + LOAD_CYCLES;
    localparam logic signed [31:0] THRESH = `CN_THRESH_MV << `CN_FRAC_BITS;
    localparam logic [31:0] SAMPLES [6] = '{32'h2800, 32'h0800, 32'h0000,
                                            32'h5000, 32'hA000, 32'h0600}; // 10, 2, 0, 20, 40, 1.5

    logic        ep50trig;
    logic        reset_global;
    logic [15:0] i_trig, i_wire00, i_wire_lo, i_wire_hi, i_pipe_data;
    logic        i_pipe_write, i_spike_ia, i_spike_ii;
    logic        o_spike_cn1, o_spike_extra1, o_spike_extra2;
    logic [31:0] o_spike_count_cn1, o_drive_cn1, o_wave;

    // reference model state updated once per edge
    logic signed [31:0] m_gain, m_extra, m_wconst, m_wave, m_ia, m_ii, m_drive;
    logic signed [31:0] m_v [3];     // cn1, extra1, extra2
    logic               m_spk [3];
    logic [31:0]        m_cnt;
    logic [31:0]        m_mem [`CN_WAVE_DEPTH];
    logic [15:0]        m_lo;
    logic               m_hi_next;
    int                 m_wr_count, m_rd;
    int                 err_count, extra1_seen, extra2_seen;
    logic [31:0]        rng;         // xorshift state

    cn_node_top UUT (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_trig(i_trig),
        .i_wire00(i_wire00), .i_wire_lo(i_wire_lo), .i_wire_hi(i_wire_hi),
        .i_pipe_write(i_pipe_write), .i_pipe_data(i_pipe_data),
        .i_spike_ia(i_spike_ia), .i_spike_ii(i_spike_ii),
        .o_spike_cn1(o_spike_cn1), .o_spike_extra1(o_spike_extra1),
        .o_spike_extra2(o_spike_extra2), .o_spike_count_cn1(o_spike_count_cn1),
        .o_drive_cn1(o_drive_cn1), .o_wave(o_wave)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // leaky integrate and fire returning {spike, new potential}
    function automatic logic [32:0] ref_neuron(input logic signed [31:0] v,
                                               input logic signed [31:0] d);
        logic signed [31:0] vn;
        vn = v + d - (v >>> `CN_LEAK_SHIFT);
        if (vn >= THRESH)
            return {1'b1, 32'h0};
        return {1'b0, vn};
    endfunction

    function automatic logic signed [31:0] ref_syn(input logic signed [31:0] cur, input logic s);
        return cur - (cur >>> `CN_SYN_DECAY_SHIFT) + (s ? `CN_SYN_WEIGHT : 0);
    endfunction

    // sum times gain shifted back to 10 fraction bits
    function automatic logic signed [31:0] ref_gain(input logic signed [31:0] sum,
                                                    input logic signed [31:0] gain);
        longint p;
        p = longint'(sum) * longint'(gain);
        return 32'(p >>> `CN_FRAC_BITS);
    endfunction

    // one edge of the whole node from pre-edge values
    task automatic model_step();
        logic signed [31:0] nxt_wave;
        int                 nxt_rd;
        logic [32:0]        n0, n1, n2;
        logic [31:0]        word;
        word = {i_wire_hi, i_wire_lo};
        if (reset_global)
        begin
            m_gain = `CN_GAIN_RESET;
            m_extra = 0;
            m_wconst = 0;
            m_wave = 0;
            m_ia = 0;
            m_ii = 0;
            m_drive = 0;
            m_v = '{0, 0, 0};
            m_spk = '{0, 0, 0};
            m_cnt = 0;
            m_hi_next = 0;
            m_wr_count = 0;
            m_rd = 0;
        end
        else
        begin
            if (!i_wire00[1])
                nxt_wave = m_wconst;            // trigger constant replaces playback
            else if (m_wr_count == 0)
                nxt_wave = 0;
            else
                nxt_wave = m_mem[m_rd];
            if (i_wire00[2] || m_wr_count == 0 || m_rd + 1 >= m_wr_count)
                nxt_rd = 0;                     // hold or wrap
            else
                nxt_rd = m_rd + 1;
            if (i_pipe_write)
            begin
                if (!m_hi_next)
                    m_lo = i_pipe_data;
                else if (m_wr_count < `CN_WAVE_DEPTH)
                begin
                    m_mem[m_wr_count] = {i_pipe_data, m_lo};
                    m_wr_count++;
                end
                m_hi_next = !m_hi_next;
            end
            if (i_wire00[2])
            begin
                m_ia = 0;
                m_ii = 0;
                m_drive = 0;
                m_v = '{0, 0, 0};
                m_spk = '{0, 0, 0};
                m_cnt = 0;
            end
            else
            begin
                n0 = ref_neuron(m_v[0], m_drive);
                n1 = ref_neuron(m_v[1], m_extra);
                n2 = ref_neuron(m_v[2], m_wave);
                m_drive = ref_gain(m_ia + m_ii, m_gain);
                m_ia = ref_syn(m_ia, i_spike_ia);
                m_ii = ref_syn(m_ii, i_spike_ii);
                m_v = '{n0[31:0], n1[31:0], n2[31:0]};
                m_spk = '{n0[32], n1[32], n2[32]};
                if (n0[32])
                    m_cnt++;
            end
            m_wave = nxt_wave;
            m_rd = nxt_rd;
            if (i_trig[`CN_TRIG_GAIN])
                m_gain = word;
            if (i_trig[`CN_TRIG_EXTRA])
                m_extra = word;
            if (i_trig[`CN_TRIG_WAVE])
                m_wconst = word;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want)
        else
        begin
            err_count++;
            $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, want, $time);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_condition(input logic ok, input string what);
        assert (ok)
        else
        begin
            err_count++;
            $display("check failed: %s", what);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge ep50trig);
        #2;
    endtask

    // one strobe on the trigger bits with the host word on the wire-ins
    task automatic load_param(input logic [15:0] mask, input logic [31:0] word);
        {i_wire_hi, i_wire_lo} = word;
        i_trig = mask;
        next_cycle();
        i_trig = '0;
    endtask

    task automatic push_pipe(input logic [15:0] data);
        i_pipe_write = 1'b1;
        i_pipe_data = data;
        next_cycle();
        i_pipe_write = 1'b0;
    endtask

    task automatic run_random(input int n);
        repeat (n)
        begin
            rng = xorshift32(rng);
            i_spike_ia = (rng[3:0] < 4'd7);
            i_spike_ii = (rng[11:8] < 4'd5);
            next_cycle();
        end
        i_spike_ia = 1'b0;
        i_spike_ii = 1'b0;
    endtask

    initial
    begin
        ep50trig = 1'b0;
        forever #CLK_HALF ep50trig = ~ep50trig;
    end

    // compare against the model just after every edge
    initial
    begin
        err_count = 0;
        extra1_seen = 0;
        extra2_seen = 0;
        forever
        begin
            @(posedge ep50trig);
            model_step();
            #1;
            check_value("o_spike_cn1", 32'(o_spike_cn1), 32'(m_spk[0]));
            check_value("o_spike_extra1", 32'(o_spike_extra1), 32'(m_spk[1]));
            check_value("o_spike_extra2", 32'(o_spike_extra2), 32'(m_spk[2]));
            check_value("o_spike_count_cn1", o_spike_count_cn1, m_cnt);
            check_value("o_drive_cn1", o_drive_cn1, m_drive);
            check_value("o_wave", o_wave, m_wave);
            if (o_spike_extra1)
                extra1_seen++;
            if (o_spike_extra2)
                extra2_seen++;
        end
    end

    initial
    begin
        #(longint'(TOTAL_CYCLES + 100) * 2 * CLK_HALF);
        $display("watchdog expired before the test sequence finished");
        $display("Test failed");
        $fatal(1);
    end

    initial
    begin
        int seen;
        reset_global = 1'b1;
        i_trig = '0;
        i_wire00 = 16'h0002;  // playback from buffer with sim running
        i_wire_lo = '0;
        i_wire_hi = '0;
        i_pipe_write = 1'b0;
        i_pipe_data = '0;
        i_spike_ia = 1'b0;
        i_spike_ii = 1'b0;
        rng = 32'd70;
        repeat (RESET_CYCLES) @(posedge ep50trig);
        #2 reset_global = 1'b0;

        // quiet node stays at 0
        repeat (IDLE_CYCLES) next_cycle();

        // constant 5.0 into extra neuron 1 and then back to 0
        load_param(16'(1 << `CN_TRIG_EXTRA), 32'h0000_1400);
        repeat (EXTRA_CYCLES) next_cycle();
        check_condition(extra1_seen > 0, "extra neuron 1 never fired under constant drive");
        load_param(16'(1 << `CN_TRIG_EXTRA), 32'h0);
        repeat (SETTLE_CYCLES) next_cycle();
        seen = extra1_seen;
        repeat (STOP_CYCLES) next_cycle();
        check_condition(extra1_seen == seen, "extra neuron 1 kept firing with zero drive");

        // random afferents with default gain and then 2.0
        run_random(RAND_CYCLES);
        load_param(16'(1 << `CN_TRIG_GAIN), 32'h0000_0800);
        run_random(RAND_CYCLES);
        check_condition(o_spike_count_cn1 != 0, "cn1 never fired under random input");

        // load six samples while held in sim_reset
        i_wire00 = 16'h0006;
        foreach (SAMPLES[k])
        begin
            push_pipe(SAMPLES[k][15:0]);
            push_pipe(SAMPLES[k][31:16]);
        end
        i_wire00 = 16'h0002;
        repeat (PLAY_CYCLES) next_cycle();
        check_condition(extra2_seen > 0, "extra neuron 2 never fired on the waveform");

        // trigger constant 3.25 in place of the buffer
        load_param(16'(1 << `CN_TRIG_WAVE), 32'h0000_0D00);
        i_wire00 = 16'h0000;
        repeat (CONST_CYCLES) next_cycle();
        check_value("o_wave", o_wave, 32'h0000_0D00);
        i_wire00 = 16'h0002;

        // sim_reset in the middle of a run
        run_random(RAND_CYCLES / 2);
        i_wire00 = 16'h0006;
        repeat (HOLD_CYCLES) next_cycle();
        check_value("o_drive_cn1", o_drive_cn1, 32'h0);
        check_value("o_spike_count_cn1", o_spike_count_cn1, 32'h0);
        i_wire00 = 16'h0002;
        run_random(RAND_CYCLES / 2);

        if (err_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* verilog/cn_node_top.sv */
`timescale 1ns/10ps

module cn_node_top
    import cn_host_pkg::*, cn_neuron_pkg::*;
(
    input  logic        ep50trig,          // 1 ms simulation tick
    input  logic        reset_global,
    input  logic [15:0] i_trig,
    input  logic [15:0] i_wire00,
    input  logic [15:0] i_wire_lo,
    input  logic [15:0] i_wire_hi,
    input  logic        i_pipe_write,
    input  logic [15:0] i_pipe_data,
    input  logic        i_spike_ia,
    input  logic        i_spike_ii,
    output logic        o_spike_cn1,
    output logic        o_spike_extra1,
    output logic        o_spike_extra2,
    output logic [31:0] o_spike_count_cn1,
    output logic [31:0] o_drive_cn1,
    output logic [31:0] o_wave
);

    host_ctrl_t  ctrl;
    param_bank_t params;
    drive_t      wave;     // buffer output into extra neuron 2
    drive_t      drive;
    neuron_out_t cn1_out;

    host_param_bank u_bank (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_trig(i_trig),
        .i_wire00(i_wire00), .i_wire_lo(i_wire_lo), .i_wire_hi(i_wire_hi),
        .o_ctrl(ctrl), .o_params(params)
    );

    wave_sample_buffer u_wave (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_ctrl(ctrl),
        .i_wave_const(params.wave_const), .i_pipe_write(i_pipe_write),
        .i_pipe_data(i_pipe_data), .o_wave(wave)
    );

    cn_drive_core u_core (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_ctrl(ctrl),
        .i_params(params), .i_wave(wave), .i_spike_ia(i_spike_ia),
        .i_spike_ii(i_spike_ii), .o_drive(drive), .o_cn1(cn1_out),
        .o_extra1_spike(o_spike_extra1), .o_extra2_spike(o_spike_extra2)
    );

    // struct fields out to flat ports
    assign o_spike_cn1       = cn1_out.spike;
    assign o_spike_count_cn1 = cn1_out.count;
    assign o_drive_cn1       = drive;
    assign o_wave            = wave;

endmodule

/* verilog/cn_drive_core.sv */
`timescale 1ns/10ps

`include "cn_params.svh"

module cn_drive_core
    import cn_host_pkg::*, cn_neuron_pkg::*;
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  host_ctrl_t  i_ctrl,
    input  param_bank_t i_params,
    input  drive_t      i_wave,      // registered wave sample, drives extra neuron 2
    input  logic        i_spike_ia,  // Ia afferent spike
    input  logic        i_spike_ii,  // II afferent spike
    output drive_t      o_drive,     // gained drive into cn1
    output neuron_out_t o_cn1,
    output logic        o_extra1_spike,
    output logic        o_extra2_spike
);

    drive_t        ia_cur;      // Ia synaptic current
    drive_t        ii_cur;      // II synaptic current
    drive_t        syn_sum;
    logic signed [63:0] gain_prod;
    drive_t        gained;
    neuron_out_t   extra1_out;
    neuron_out_t   extra2_out;

    // one tick of exponential decay plus the input kick
    function automatic drive_t syn_step(input drive_t cur, input logic spike);
        drive_t kick;
        kick = spike ? drive_t'(`CN_SYN_WEIGHT) : drive_t'(0);
        return cur - (cur >>> `CN_SYN_DECAY_SHIFT) + kick;
    endfunction

    assign syn_sum   = ia_cur + ii_cur;
    assign gain_prod = 64'(syn_sum) * 64'(i_params.gain); // q.20 product
    assign gained    = gain_prod[`CN_FRAC_BITS +: 32];    // back to q.10

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            ia_cur  <= '0;
            ii_cur  <= '0;
            o_drive <= '0;
        end
        else if (i_ctrl.sim_reset)
        begin
            ia_cur  <= '0;
            ii_cur  <= '0;
            o_drive <= '0;
        end
        else
        begin
            ia_cur  <= syn_step(ia_cur, i_spike_ia);
            ii_cur  <= syn_step(ii_cur, i_spike_ii);
            o_drive <= gained;  // latched from the pre-edge currents
        end
    end

    // main cortical neuron, the only one with a counter
    if_neuron #(.HAS_COUNTER(1'b1)) u_cn1 (
        .ep50trig    (ep50trig),
        .reset_global(reset_global),
        .i_sim_reset (i_ctrl.sim_reset),
        .i_drive     (o_drive),
        .o_out       (o_cn1)
    );

    // extra neuron 1, host constant drive
    if_neuron #(.HAS_COUNTER(1'b0)) u_extra1 (
        .ep50trig    (ep50trig),
        .reset_global(reset_global),
        .i_sim_reset (i_ctrl.sim_reset),
        .i_drive     (i_params.extra_drive),
        .o_out       (extra1_out)
    );

    // extra neuron 2, waveform drive
    if_neuron #(.HAS_COUNTER(1'b0)) u_extra2 (
        .ep50trig    (ep50trig),
        .reset_global(reset_global),
        .i_sim_reset (i_ctrl.sim_reset),
        .i_drive     (i_wave),
        .o_out       (extra2_out)
    );

    assign o_extra1_spike = extra1_out.spike;
    assign o_extra2_spike = extra2_out.spike;

    // decay by a right shift can never take a current below 0
    a_cur_nonneg: assert property (@(posedge ep50trig) disable iff (reset_global)
        (ia_cur >= 0) && (ii_cur >= 0));

endmodule

/* verilog/if_neuron.sv */
`timescale 1ns/10ps

`include "cn_params.svh"

module if_neuron
    import cn_neuron_pkg::*;
#(
    parameter bit HAS_COUNTER = 1'b1 // 0 keeps the count field at 0
)
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        i_sim_reset,  // synchronous clear of the neuron state
    input  drive_t      i_drive,      // input current, already registered upstream
    output neuron_out_t o_out
);

    localparam drive_t THRESH = drive_t'(`CN_THRESH_MV <<< `CN_FRAC_BITS); // 30 mV

    drive_t v_q;     // membrane potential
    drive_t v_next;
    logic   fire;

    // leaky integrate, v + I - v/8
    assign v_next = v_q + i_drive - (v_q >>> `CN_LEAK_SHIFT);
    assign fire   = (v_next >= THRESH);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            v_q   <= '0;
            o_out <= '0;
        end
        else if (i_sim_reset)
        begin
            v_q   <= '0;
            o_out <= '0;
        end
        else
        begin
            v_q         <= fire ? drive_t'(0) : v_next; // reset to 0 after a spike
            o_out.spike <= fire;
            if (HAS_COUNTER && fire)
                o_out.count <= o_out.count + 1'b1;
        end
    end

    // a quiet tick always leaves the potential under threshold
    a_subthresh: assert property (@(posedge ep50trig) disable iff (reset_global)
        !i_sim_reset |=> (o_out.spike || v_q < THRESH));

endmodule

/* verilog/wave_sample_buffer.sv */
`timescale 1ns/10ps

`include "cn_params.svh"

module wave_sample_buffer
    import cn_host_pkg::*, cn_neuron_pkg::*;
(
    input  logic       ep50trig,
    input  logic       reset_global,
    input  host_ctrl_t i_ctrl,
    input  drive_t     i_wave_const,  // trigger constant, used when from_trigger
    input  logic       i_pipe_write,  // one 16 bit word per strobe
    input  logic [15:0] i_pipe_data,
    output drive_t     o_wave         // one sample per tick
);

    localparam int DEPTH = `CN_WAVE_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    drive_t       mem [DEPTH]; // sample store
    logic [15:0]  lo_half;     // low half waiting for its high half
    logic         hi_next;     // next pipe word is the high half
    logic [AW:0]  wr_count;    // samples written, one bit wider to hold DEPTH
    logic [AW-1:0] rd_ptr;
    logic [AW:0]  rd_ptr_inc;
    logic         wr_sample;   // high half arriving with room left
    drive_t       wave_d;

    assign wr_sample  = i_pipe_write && hi_next && (wr_count < (AW+1)'(DEPTH));
    assign rd_ptr_inc = {1'b0, rd_ptr} + 1'b1;

    // pipe side, only reset_global restarts the write sequence
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            hi_next  <= 1'b0;
            wr_count <= '0;
        end
        else if (i_pipe_write)
        begin
            hi_next <= ~hi_next;  // low, high, low, high ...
            if (wr_sample)
                wr_count <= wr_count + 1'b1;
        end
    end

    // store and low half latch
    always_ff @(posedge ep50trig)
    begin
        if (i_pipe_write && !hi_next)
            lo_half <= i_pipe_data;
        if (wr_sample)
            mem[wr_count[AW-1:0]] <= {i_pipe_data, lo_half}; // sample lands on the high half
    end

    // output mux, sample at the pre-edge pointer
    always_comb
    begin
        if (i_ctrl.from_trigger)
            wave_d = i_wave_const;
        else if (wr_count == '0)
            wave_d = '0;  // nothing loaded yet
        else
            wave_d = mem[rd_ptr];
    end

    // playback pointer, wraps at the written length
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            rd_ptr <= '0;
            o_wave <= '0;
        end
        else
        begin
            o_wave <= wave_d;
            if (i_ctrl.sim_reset || wr_count == '0)
                rd_ptr <= '0;  // held at the first sample
            else if (rd_ptr_inc >= wr_count)
                rd_ptr <= '0;  // wrap
            else
                rd_ptr <= rd_ptr_inc[AW-1:0];
        end
    end

    // write count saturates at the buffer size
    a_count_bound: assert property (@(posedge ep50trig) disable iff (reset_global)
        wr_count <= (AW+1)'(DEPTH));

    // playback never points past what the pipe has written
    a_ptr_in_range: assert property (@(posedge ep50trig) disable iff (reset_global)
        (wr_count != '0) |-> ({1'b0, rd_ptr} < wr_count));

endmodule

/* verilog/host_param_bank.sv */
`timescale 1ns/10ps

`include "cn_params.svh"

module host_param_bank
    import cn_host_pkg::*, cn_neuron_pkg::*;
(
    input  logic                   ep50trig,     // simulation tick, 1 ms
    input  logic                   reset_global,
    input  logic [15:0]            i_trig,       // one cycle strobes
    input  logic [15:0]            i_wire00,     // run control levels
    input  logic [HOST_HALF_W-1:0] i_wire_lo,    // host word bits 15:0
    input  logic [HOST_HALF_W-1:0] i_wire_hi,    // host word bits 31:16
    output host_ctrl_t             o_ctrl,
    output param_bank_t            o_params
);

    // values the bank comes out of reset with
    localparam param_bank_t BANK_RESET = '{
        gain:        drive_t'(`CN_GAIN_RESET),
        extra_drive: drive_t'(0),
        wave_const:  drive_t'(0)
    };

    drive_t      host_word; // assembled 32 bit value from the two wire-ins
    param_bank_t bank_q;

    assign host_word = drive_t'({i_wire_hi, i_wire_lo});

    // plain decode, no register
    assign o_ctrl.sim_reset    = i_wire00[2];
    assign o_ctrl.from_trigger = ~i_wire00[1]; // bit 1 low selects trigger constant

    // each register loads on its own strobe
    // several strobes in one tick all take the same word
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            bank_q <= BANK_RESET;
        end
        else
        begin
            if (i_trig[`CN_TRIG_GAIN])
                bank_q.gain <= host_word;        // syn gain
            if (i_trig[`CN_TRIG_EXTRA])
                bank_q.extra_drive <= host_word; // extra cortical drive, node 1
            if (i_trig[`CN_TRIG_WAVE])
                bank_q.wave_const <= host_word;  // constant wave, node 2
        end
    end

    assign o_params = bank_q;

endmodule

/* verilog/cn_host_pkg.sv */
package cn_host_pkg;

    import cn_neuron_pkg::*;

    // run control decoded from wire00
    typedef struct packed {
        logic sim_reset;    // wire00 bit 2, holds the simulation state at 0
        logic from_trigger; // inverse of wire00 bit 1, wave taken from trigger register
    } host_ctrl_t;

    // trigger loaded parameter registers
    typedef struct packed {
        drive_t gain;        // synaptic gain, 1.0 after reset
        drive_t extra_drive; // constant drive into extra neuron 1
        drive_t wave_const;  // replaces the buffer output when from_trigger
    } param_bank_t;

    // host word is two 16 bit wire-ins
    localparam int HOST_HALF_W = 16;

endpackage

/* verilog/cn_neuron_pkg.sv */
package cn_neuron_pkg;

    // signed fixed point current or potential
    // all datapath values share this one format
    typedef logic signed [31:0] drive_t;

    // what one neuron reports per tick
    typedef struct packed {
        logic        spike; // high for the tick the neuron fired
        logic [31:0] count; // running spike total, 0 when no counter
    } neuron_out_t;

    // sizes of the above, handy for width checks
    localparam int DRIVE_W = $bits(drive_t);
    localparam int NEURON_OUT_W = $bits(neuron_out_t);

endpackage

/* include/cn_params.svh */
`ifndef CN_PARAMS_SVH
`define CN_PARAMS_SVH

// fixed point format, q21.10 in a signed 32 bit word
`define CN_FRAC_BITS 10

// firing threshold in mV, scaled by CN_FRAC_BITS at the compare
`define CN_THRESH_MV 30

// membrane leak is v >>> CN_LEAK_SHIFT per tick
`define CN_LEAK_SHIFT 3

// synaptic current decay is I >>> CN_SYN_DECAY_SHIFT per tick
`define CN_SYN_DECAY_SHIFT 4
`define CN_SYN_WEIGHT 2048 // 2.0 added per input spike

// waveform buffer size in 32 bit samples
`define CN_WAVE_DEPTH 256

// trigger bit indices of the host strobe word
`define CN_TRIG_GAIN 3
`define CN_TRIG_EXTRA 8
`define CN_TRIG_WAVE 9
`define CN_GAIN_RESET 1024 // 1.0

`endif
